/* design/lsu_types_pkg.sv */
// Instruction-side types; only the eight RV32I load/store ops are encoded, no atomics or fences
`default_nettype none

package lsu_types_pkg;

    typedef logic [31:0] word_t;     // Register value
    typedef logic [4:0]  reg_idx_t;  // Register index
    typedef logic [11:0] imm12_t;    // I/S-type immediate, sign-extended on use

    typedef enum logic [2:0] {
        OP_LB  = 3'd0,
        OP_LBU = 3'd1,
        OP_LH  = 3'd2,
        OP_LHU = 3'd3,
        OP_LW  = 3'd4,
        OP_SB  = 3'd5,
        OP_SH  = 3'd6,
        OP_SW  = 3'd7
    } mem_op_e;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } access_size_e;

    typedef struct packed {
        mem_op_e  op;
        reg_idx_t rd;          // Ignored for stores
        word_t    base;        // rs1 value
        word_t    store_data;  // rs2 value
        imm12_t   imm;
    } lsu_issue_t;

    typedef struct packed {
        reg_idx_t rd;
        word_t    data;            // Zero for stores and failed accesses
        logic     is_load;
        logic     err_misaligned;
        logic     err_timeout;
    } lsu_result_t;

endpackage

`default_nettype wire

/* design/mem_bus_pkg.sv */
// Word-wide memory bus types; addresses are byte addresses but always word aligned on the bus
`default_nettype none

package mem_bus_pkg;

    typedef logic [31:0] bus_addr_t;  // Byte address
    typedef logic [31:0] bus_data_t;  // One word, four byte lanes
    typedef logic [3:0]  byte_en_t;   // One bit per lane, bit 0 is the lowest address

    // Request payload, qualified by mem_req_valid
    typedef struct packed {
        bus_addr_t addr;
        bus_data_t wdata;
        byte_en_t  be;
        logic      write;  // High for stores
    } mem_req_t;

    // Response payload, valid only in the cycle of mem_ready
    typedef struct packed {
        bus_data_t rdata;
    } mem_rsp_t;

endpackage

`default_nettype wire

/* design/lsu_addr_gen.sv */
// Holds one instruction at a time; outputs are stable from the cycle after capture until the next
`timescale 1ns/1ps
`default_nettype none

module lsu_addr_gen
    import lsu_types_pkg::*;
    import mem_bus_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         capture,
    input  lsu_issue_t   issue,
    output mem_op_e      op,
    output reg_idx_t     rd,
    output word_t        store_data,
    output bus_addr_t    addr,
    output access_size_e size,
    output logic         is_load,
    output logic         misaligned
);

    word_t imm_ext;

    assign imm_ext = {{20{issue.imm[11]}}, issue.imm};  // Sign extension for every op

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            op         <= OP_LW;
            rd         <= '0;
            store_data <= '0;
            addr       <= '0;
        end else if (capture) begin
            op         <= issue.op;
            rd         <= issue.rd;
            store_data <= issue.store_data;
            addr       <= bus_addr_t'(issue.base + imm_ext);
        end
    end

    always_comb begin
        unique case (op)
            OP_LB, OP_LBU, OP_SB: size = SIZE_BYTE;
            OP_LH, OP_LHU, OP_SH: size = SIZE_HALF;
            default:              size = SIZE_WORD;
        endcase
    end

    assign is_load = (op == OP_LB) || (op == OP_LBU) || (op == OP_LH) ||
                     (op == OP_LHU) || (op == OP_LW);

    // Natural alignment only, bytes never fault
    assign misaligned = ((size == SIZE_HALF) && addr[0]) ||
                        ((size == SIZE_WORD) && (addr[1:0] != 2'b00));

endmodule

`default_nettype wire

/* design/lsu_ctrl_fsm.sv */
// One access in flight; a grant and a timeout in the same cycle count as a grant
`timescale 1ns/1ps
`default_nettype none

module lsu_ctrl_fsm (
    input  logic clk,
    input  logic rst,
    input  logic issue_valid,
    input  logic misaligned,
    input  logic is_load,
    input  logic mem_ready,
    input  logic expired,
    output logic capture,
    output logic timer_run,
    output logic mem_req_valid,
    output logic load_capture,
    output logic done_valid,
    output logic err_misaligned,
    output logic err_timeout,
    output logic busy
);

    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        CHECK   = 2'd1,  // Captured instruction is decoded, alignment known
        REQUEST = 2'd2,  // Waiting for mem_ready
        FINISH  = 2'd3   // Bus access ended, report it
    } state_e;

    state_e state;
    state_e state_next;
    logic   timeout_q;   // Reason the bus phase ended
    logic   bus_end;

    // Request is raised straight from CHECK so it appears one cycle after issue
    assign mem_req_valid = ((state == CHECK) && !misaligned) || (state == REQUEST);
    assign bus_end       = mem_req_valid && (mem_ready || expired);

    assign capture        = (state == IDLE) && issue_valid;  // Strobes while busy are dropped
    assign timer_run      = mem_req_valid;
    assign load_capture   = mem_req_valid && mem_ready && is_load;
    assign busy           = (state != IDLE);

    // Misalignment is reported from CHECK, bus outcomes from FINISH
    assign done_valid     = ((state == CHECK) && misaligned) || (state == FINISH);
    assign err_misaligned = (state == CHECK) && misaligned;
    assign err_timeout    = (state == FINISH) && timeout_q;

    always_comb begin
        state_next = state;
        unique case (state)
            IDLE: begin
                if (issue_valid) state_next = CHECK;
            end
            CHECK: begin
                if (misaligned)   state_next = IDLE;
                else if (bus_end) state_next = FINISH;
                else              state_next = REQUEST;
            end
            REQUEST: begin
                if (bus_end) state_next = FINISH;
            end
            FINISH: begin
                state_next = IDLE;
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= IDLE;
            timeout_q <= 1'b0;
        end else begin
            state <= state_next;
            if (bus_end) begin
                timeout_q <= !mem_ready;  // Grant takes priority
            end
        end
    end

endmodule

`default_nettype wire

/* design/lsu_wait_timer.sv */
// TIMEOUT_CYCLES must lie in 2..255; expired is combinational and only valid while run is high
`timescale 1ns/1ps
`default_nettype none

module lsu_wait_timer #(
    parameter int TIMEOUT_CYCLES = 16
) (
    input  logic clk,
    input  logic rst,
    input  logic run,
    output logic expired
);

    localparam int CNT_W = $clog2(TIMEOUT_CYCLES);

    typedef logic [CNT_W-1:0] count_t;

    localparam count_t LAST = count_t'(TIMEOUT_CYCLES - 1);

    count_t cnt;  // Completed run cycles before the current one

    // Current cycle is number cnt+1, so this is the TIMEOUT_CYCLES-th
    assign expired = run && (cnt == LAST);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt <= '0;
        end else if (!run) begin
            cnt <= '0;              // Fresh count for every request
        end else if (cnt != LAST) begin
            cnt <= cnt + count_t'(1);
        end
    end

endmodule

`default_nettype wire

/* design/lsu_store_align.sv */
// Purely combinational; assumes the access is aligned, misaligned ops never reach the bus
`timescale 1ns/1ps
`default_nettype none

module lsu_store_align
    import lsu_types_pkg::*;
    import mem_bus_pkg::*;
(
    input  bus_addr_t    addr,
    input  access_size_e size,
    input  word_t        store_data,
    input  logic         is_load,
    output mem_req_t     req
);

    bus_data_t wdata;
    byte_en_t  lane_be;

    always_comb begin
        unique case (size)
            SIZE_BYTE: begin
                wdata   = {4{store_data[7:0]}};        // Same byte on every lane
                lane_be = byte_en_t'(4'b0001 << addr[1:0]);
            end
            SIZE_HALF: begin
                wdata   = {2{store_data[15:0]}};
                lane_be = addr[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                wdata   = store_data;
                lane_be = 4'b1111;
            end
        endcase
    end

    assign req.addr  = {addr[31:2], 2'b00};
    assign req.wdata = wdata;
    assign req.be    = is_load ? 4'b1111 : lane_be;  // Loads read the full word
    assign req.write = !is_load;

endmodule

`default_nettype wire

/* design/lsu_load_extend.sv */
// Lane is picked from the effective address; load_data holds until the next load completes
`timescale 1ns/1ps
`default_nettype none

module lsu_load_extend
    import lsu_types_pkg::*;
    import mem_bus_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      load_capture,
    input  mem_op_e   op,
    input  bus_addr_t addr,
    input  mem_rsp_t  rsp,
    output word_t     load_data
);

    logic [7:0]  byte_sel;
    logic [15:0] half_sel;
    word_t       ext_data;

    assign byte_sel = rsp.rdata[8*addr[1:0] +: 8];
    assign half_sel = addr[1] ? rsp.rdata[31:16] : rsp.rdata[15:0];

    always_comb begin
        unique case (op)
            OP_LB:   ext_data = {{24{byte_sel[7]}}, byte_sel};
            OP_LBU:  ext_data = {24'd0, byte_sel};
            OP_LH:   ext_data = {{16{half_sel[15]}}, half_sel};
            OP_LHU:  ext_data = {16'd0, half_sel};
            OP_LW:   ext_data = rsp.rdata;
            default: ext_data = '0;  // Stores carry no data
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            load_data <= '0;
        end else if (load_capture) begin
            load_data <= ext_data;  // rdata is only valid in the mem_ready cycle
        end
    end

endmodule

`default_nettype wire

/* design/lsu_top.sv */
// Issue only while busy is low; result is valid only with done_valid, mem_rsp only with mem_ready
`timescale 1ns/1ps
`default_nettype none

module lsu_top
    import lsu_types_pkg::*;
    import mem_bus_pkg::*;
#(
    parameter int TIMEOUT_CYCLES = 16
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        issue_valid,
    input  lsu_issue_t  issue,
    input  logic        mem_ready,
    input  mem_rsp_t    mem_rsp,
    output logic        busy,
    output logic        mem_req_valid,
    output mem_req_t    mem_req,
    output logic        done_valid,
    output lsu_result_t result
);

    mem_op_e      op;
    reg_idx_t     rd;
    word_t        store_data;
    bus_addr_t    addr;
    access_size_e size;
    logic         is_load;
    logic         misaligned;
    logic         capture;
    logic         timer_run;
    logic         expired;
    logic         load_capture;
    logic         err_misaligned;
    logic         err_timeout;
    word_t        load_data;

    lsu_addr_gen u_addr_gen (
        .clk        (clk),
        .rst        (rst),
        .capture    (capture),
        .issue      (issue),
        .op         (op),
        .rd         (rd),
        .store_data (store_data),
        .addr       (addr),
        .size       (size),
        .is_load    (is_load),
        .misaligned (misaligned)
    );

    lsu_ctrl_fsm u_ctrl_fsm (
        .clk            (clk),
        .rst            (rst),
        .issue_valid    (issue_valid),
        .misaligned     (misaligned),
        .is_load        (is_load),
        .mem_ready      (mem_ready),
        .expired        (expired),
        .capture        (capture),
        .timer_run      (timer_run),
        .mem_req_valid  (mem_req_valid),
        .load_capture   (load_capture),
        .done_valid     (done_valid),
        .err_misaligned (err_misaligned),
        .err_timeout    (err_timeout),
        .busy           (busy)
    );

    lsu_wait_timer #(
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
    ) u_wait_timer (
        .clk     (clk),
        .rst     (rst),
        .run     (timer_run),
        .expired (expired)
    );

    lsu_store_align u_store_align (
        .addr       (addr),
        .size       (size),
        .store_data (store_data),
        .is_load    (is_load),
        .req        (mem_req)
    );

    lsu_load_extend u_load_extend (
        .clk          (clk),
        .rst          (rst),
        .load_capture (load_capture),
        .op           (op),
        .addr         (addr),
        .rsp          (mem_rsp),
        .load_data    (load_data)
    );

    // Failed loads return zero like stores
    assign result = '{
        rd:             rd,
        data:           (is_load && !err_misaligned && !err_timeout) ? load_data : '0,
        is_load:        is_load,
        err_misaligned: err_misaligned,
        err_timeout:    err_timeout
    };

endmodule

`default_nettype wire

/* verification/lsu_props.sv */
// Bound into lsu_top; assumes one access in flight and a memory that may withhold mem_ready
`timescale 1ns/1ps
`default_nettype none

module lsu_props
    import lsu_types_pkg::*;
    import mem_bus_pkg::*;
#(
    parameter int TIMEOUT_CYCLES = 16
) (
    input logic        clk,
    input logic        rst,
    input logic        issue_valid,
    input logic        busy,
    input logic        mem_req_valid,
    input mem_req_t    mem_req,
    input logic        mem_ready,
    input logic        done_valid,
    input lsu_result_t result
);

    int   fail_count = 0;
    int   req_len;   // Request cycles before the current one
    logic pending;   // Accepted issue still waiting for done_valid

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            req_len <= 0;
            pending <= 1'b0;
        end else begin
            req_len <= mem_req_valid ? req_len + 1 : 0;
            if (issue_valid && !pending) begin
                pending <= 1'b1;
            end else if (done_valid) begin
                pending <= 1'b0;
            end
        end
    end

    no_issue_while_busy: assert property (@(posedge clk) disable iff (rst)
        issue_valid |-> !busy)
        else begin
            fail_count++;
            $error("issue_valid pulsed while busy");
        end

    // High from the cycle after issue through the cycle of done_valid
    busy_window: assert property (@(posedge clk) disable iff (rst)
        busy == pending)
        else begin
            fail_count++;
            $error("busy does not cover exactly the access in flight");
        end

    issue_response: assert property (@(posedge clk) disable iff (rst)
        issue_valid && !pending |=> mem_req_valid || (done_valid && result.err_misaligned))
        else begin
            fail_count++;
            $error("neither a request nor a misaligned completion in the cycle after issue");
        end

    // Held until granted, except in the cycle where the timer runs out
    req_stable: assert property (@(posedge clk) disable iff (rst)
        mem_req_valid && !mem_ready && (req_len < TIMEOUT_CYCLES - 1)
            |=> mem_req_valid && $stable(mem_req))
        else begin
            fail_count++;
            $error("mem_req dropped or changed before mem_ready");
        end

    done_after_grant: assert property (@(posedge clk) disable iff (rst)
        mem_req_valid && mem_ready |=> done_valid && !result.err_timeout)
        else begin
            fail_count++;
            $error("no done_valid one cycle after mem_ready");
        end

    grant_before_done: assert property (@(posedge clk) disable iff (rst)
        done_valid && !result.err_misaligned && !result.err_timeout
            |-> $past(mem_req_valid && mem_ready))
        else begin
            fail_count++;
            $error("done_valid without a grant in the cycle before");
        end

    timeout_length: assert property (@(posedge clk) disable iff (rst)
        done_valid && result.err_timeout
            |-> $past(mem_req_valid) && ($past(req_len) == TIMEOUT_CYCLES - 1)
                && !mem_req_valid)
        else begin
            fail_count++;
            $error("timed out request did not last TIMEOUT_CYCLES");
        end

    misaligned_no_bus: assert property (@(posedge clk) disable iff (rst)
        done_valid && result.err_misaligned |-> !mem_req_valid && !$past(mem_req_valid))
        else begin
            fail_count++;
            $error("misaligned access reached the bus");
        end

    one_done_per_issue: assert property (@(posedge clk) disable iff (rst)
        done_valid |-> pending)
        else begin
            fail_count++;
            $error("done_valid without an accepted issue");
        end

endmodule

`default_nettype wire

/* verification/lsu_tb.sv */
// Memory model holds 64 words, so addresses alias every 256 bytes; TIMEOUT_CYCLES is fixed at 16
`timescale 1ns/1ps
`default_nettype none

module lsu_tb
    import lsu_types_pkg::*;
    import mem_bus_pkg::*;
();

    localparam int          TIMEOUT_CYCLES = 16;
    localparam int          N_DIRECTED     = 40;   // Upper bound on the scripted accesses
    localparam int          N_RANDOM       = 200;
    localparam int          MAX_CYCLES     = (N_DIRECTED + N_RANDOM) * 40 + 100;
    localparam logic [31:0] SEED           = 32'h644a;

    logic        clk;
    logic        rst;
    logic        issue_valid;
    lsu_issue_t  issue;
    logic        mem_ready = 1'b0;
    mem_rsp_t    mem_rsp   = '0;
    logic        busy;
    logic        mem_req_valid;
    mem_req_t    mem_req;
    logic        done_valid;
    lsu_result_t result;

    word_t       mem [64];      // Bus-side contents
    word_t       ref_mem [64];  // Expected contents, from the instruction rules
    logic        stall;         // Withholds mem_ready while set
    logic        in_req;
    int          wait_left;
    bus_addr_t   exp_addr;      // Expected bus request of the access in flight
    logic        exp_write;
    byte_en_t    exp_be;
    logic [31:0] lat_state  = SEED;
    logic [31:0] stim_state = SEED;
    int          checks     = 0;
    int          errors     = 0;
    int          bus_errors = 0;
    int          mem_errors = 0;
    int          prop_errors;

    lsu_top #(
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
    ) uut (
        .clk (clk), .rst (rst), .issue_valid (issue_valid), .issue (issue),
        .mem_ready (mem_ready), .mem_rsp (mem_rsp), .busy (busy),
        .mem_req_valid (mem_req_valid), .mem_req (mem_req),
        .done_valid (done_valid), .result (result)
    );

    bind lsu_top lsu_props #(
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
    ) u_props (
        .clk (clk), .rst (rst), .issue_valid (issue_valid), .busy (busy),
        .mem_req_valid (mem_req_valid), .mem_req (mem_req), .mem_ready (mem_ready),
        .done_valid (done_valid), .result (result)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Lanes 0 and 1 have bit 7 clear, lanes 2 and 3 have it set
    function automatic word_t fill_word(input logic [5:0] idx);
        return 32'h9AC5_3E71 ^ {4{2'b00, idx}};
    endfunction

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        repeat (MAX_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the DUT stopped completing accesses",
                 MAX_CYCLES);
        $display("Test failures found");
        $finish;
    end

    // Memory model, answers after 0 to 6 wait cycles
    always @(negedge clk) begin : mem_model
        int k;
        mem_ready = 1'b0;
        mem_rsp   = '0;
        if (rst) begin
            in_req = 1'b0;
            for (k = 0; k < 64; k++) mem[k] = fill_word(6'(k));
        end else if (!mem_req_valid) begin
            in_req = 1'b0;
        end else begin
            if (!in_req) begin
                in_req    = 1'b1;
                lat_state = xorshift32(lat_state);
                wait_left = int'(lat_state % 7);
                assert (mem_req.addr === exp_addr && mem_req.write === exp_write &&
                        mem_req.be === exp_be) else begin
                    bus_errors++;
                    $display("MISMATCH at %0t: request %h, expected addr %h write %b be %b",
                             $time, mem_req, exp_addr, exp_write, exp_be);
                end
            end
            if (!stall && wait_left == 0) begin
                mem_rsp.rdata = mem[mem_req.addr[7:2]];
                for (k = 0; k < 4; k++) begin
                    if (mem_req.write && mem_req.be[k])
                        mem[mem_req.addr[7:2]][8 * k +: 8] = mem_req.wdata[8 * k +: 8];
                end
                mem_ready = 1'b1;
            end else if (wait_left != 0) begin
                wait_left--;
            end
        end
    end

    task automatic run_access(input mem_op_e op, input word_t base, input imm12_t imm,
                              input word_t sdata, input reg_idx_t rd);
        word_t       ea;
        word_t       lane_word;
        lsu_result_t exp_res;
        int          nbytes;
        int          b;
        ea      = base + {{20{imm[11]}}, imm};
        nbytes  = (op inside {OP_LB, OP_LBU, OP_SB}) ? 1 :
                  (op inside {OP_LH, OP_LHU, OP_SH}) ? 2 : 4;
        exp_res = '0;
        exp_res.rd      = rd;
        exp_res.is_load = (op inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW});
        exp_addr  = {ea[31:2], 2'b00};
        exp_write = !exp_res.is_load;
        exp_be    = exp_write ? byte_en_t'(((1 << nbytes) - 1) << ea[1:0]) : 4'hF;
        if ((ea[1:0] & 2'(nbytes - 1)) != 2'b00) begin
            exp_res.err_misaligned = 1'b1;
        end else if (stall) begin
            exp_res.err_timeout = 1'b1;
        end else if (exp_res.is_load) begin
            lane_word = ref_mem[ea[7:2]] >> (8 * ea[1:0]);
            case (op)
                OP_LB:   exp_res.data = {{24{lane_word[7]}}, lane_word[7:0]};
                OP_LBU:  exp_res.data = {24'd0, lane_word[7:0]};
                OP_LH:   exp_res.data = {{16{lane_word[15]}}, lane_word[15:0]};
                OP_LHU:  exp_res.data = {16'd0, lane_word[15:0]};
                default: exp_res.data = lane_word;
            endcase
        end else begin
            for (b = 0; b < nbytes; b++)
                ref_mem[ea[7:2]][8 * (int'(ea[1:0]) + b) +: 8] = sdata[8 * b +: 8];
        end
        @(negedge clk);
        issue_valid = 1'b1;
        issue       = '{op: op, rd: rd, base: base, store_data: sdata, imm: imm};
        @(negedge clk);
        issue_valid = 1'b0;
        while (!done_valid) @(negedge clk);
        checks++;
        assert (result === exp_res) else begin
            errors++;
            $display("MISMATCH at %0t: %s at %h returned %h, expected %h",
                     $time, op.name(), ea, result, exp_res);
        end
    endtask

    initial begin
        int          i;
        logic [31:0] r;
        logic [31:0] d;
        rst         = 1'b1;
        issue_valid = 1'b0;
        issue       = '0;
        stall       = 1'b0;
        for (i = 0; i < 64; i++) ref_mem[i] = fill_word(6'(i));
        repeat (3) @(negedge clk);
        rst = 1'b0;

        for (i = 0; i < 4; i++) begin  // Every store lane, read back as a word
            run_access(OP_SB, 32'h40, imm12_t'(i), 32'h1234_5680 + i, 5'd1);
            run_access(OP_LW, 32'h40, 12'h000, 32'h0, 5'd2);
        end
        for (i = 0; i < 2; i++) begin
            run_access(OP_SH, 32'h44, imm12_t'(2 * i), 32'hCAFE_8001 + i, 5'd3);
            run_access(OP_LW, 32'h44, 12'h000, 32'h0, 5'd4);
        end
        run_access(OP_SW, 32'h48, 12'h000, 32'h1357_9BDF, 5'd5);
        run_access(OP_LW, 32'h48, 12'h000, 32'h0, 5'd6);
        run_access(OP_SW, 32'h54, 12'hFF8, 32'hFEDC_BA98, 5'd7);  // Negative offset
        run_access(OP_LW, 32'h4C, 12'h000, 32'h0, 5'd8);

        for (i = 0; i < 4; i++) begin
            run_access(OP_LB, 32'h50, imm12_t'(i), 32'h0, 5'd9);
            run_access(OP_LBU, 32'h50, imm12_t'(i), 32'h0, 5'd10);
        end
        for (i = 0; i < 4; i += 2) begin
            run_access(OP_LH, 32'h50, imm12_t'(i), 32'h0, 5'd11);
            run_access(OP_LHU, 32'h50, imm12_t'(i), 32'h0, 5'd12);
        end

        run_access(OP_LH, 32'h50, 12'h001, 32'h0, 5'd13);
        run_access(OP_LHU, 32'h50, 12'h003, 32'h0, 5'd14);
        run_access(OP_LW, 32'h50, 12'h002, 32'h0, 5'd15);
        run_access(OP_LW, 32'h53, 12'h000, 32'h0, 5'd16);
        run_access(OP_SH, 32'h44, 12'h001, 32'hFFFF_FFFF, 5'd17);
        run_access(OP_SW, 32'h48, 12'h003, 32'hFFFF_FFFF, 5'd18);
        run_access(OP_SW, 32'h4E, 12'h000, 32'hFFFF_FFFF, 5'd19);

        stall = 1'b1;  // Memory never answers in this window
        run_access(OP_LW, 32'h50, 12'h000, 32'h0, 5'd20);
        run_access(OP_SB, 32'h60, 12'h001, 32'h0000_00EE, 5'd21);
        stall = 1'b0;

        for (i = 0; i < N_RANDOM; i++) begin
            stim_state = xorshift32(stim_state);
            r          = stim_state;
            stim_state = xorshift32(stim_state);
            d          = stim_state;
            run_access(mem_op_e'(r[2:0]), {24'd0, r[7:2], 2'b00},
                       r[31] ? r[19:8] : {r[19:10], 2'b00}, d, r[24:20]);
        end

        for (i = 0; i < 64; i++) begin
            assert (mem[i] === ref_mem[i]) else begin
                mem_errors++;
                $display("MISMATCH at %0t: memory word %0d holds %h, expected %h",
                         $time, i, mem[i], ref_mem[i]);
            end
        end
        prop_errors = uut.u_props.fail_count;
        $display("Checks: %0d, failures: result %0d, bus %0d, memory %0d, assertion %0d",
                 checks, errors, bus_errors, mem_errors, prop_errors);
        if (errors == 0 && bus_errors == 0 && mem_errors == 0 && prop_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
design/lsu_types_pkg.sv
design/mem_bus_pkg.sv
design/lsu_addr_gen.sv
design/lsu_ctrl_fsm.sv
design/lsu_wait_timer.sv
design/lsu_store_align.sv
design/lsu_load_extend.sv
design/lsu_top.sv
verification/lsu_props.sv
verification/lsu_tb.sv

/* Makefile */
# Verilator flow for the load/store unit testbench
VERILATOR ?= verilator
TOP       ?= lsu_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= All tests passed!

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# The log decides the outcome, since the simulator exit code does not
run: compile
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
